// ==== src.f ====
rtl/demodPkg.sv
rtl/inputReclock.sv
rtl/sourceSelect.sv
rtl/dacDrive.sv
rtl/miscRegs.sv
rtl/resetStretch.sv
rtl/demodOutTop.sv
tb/demodOut_properties.sv
tb/tbDemodOut.sv

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tbDemodOut \
  && ./obj_dir/VtbDemodOut > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "Simulation did not complete"; exit 1; }
exit 0

// ==== tb/tbDemodOut.sv ====
// Testbench for the demodulator output side, random stimulus against a cycle model
`timescale 1ns/1ps

module tbDemodOut;

  localparam logic [demodPkg::BUS_WIDTH-1:0] VERSION = 16'h00A5;
  localparam int HOLD_CYCLES = 6;
  localparam int MSB = demodPkg::DAC_WIDTH - 1;

  typedef struct packed {
    demodPkg::demodMode_e                       mode;
    demodPkg::dacSel_e [demodPkg::NUM_DAC-1:0]  sel;
    demodPkg::dacWord_t [demodPkg::NUM_DAC-1:0] ext;
    demodPkg::trellisOut_t                      trellis;
    demodPkg::legacyIn_t                        legacy;
  } stimRec_t;

  logic ck933;
  logic rs;
  logic cs;
  logic rd;
  integer seed = 84;
  demodPkg::demodMode_e                         mode;
  demodPkg::dacSel_e [demodPkg::NUM_DAC-1:0]    dacSel;
  demodPkg::dacWord_t [demodPkg::NUM_DAC-1:0]   extDac;
  demodPkg::trellisOut_t                        trellis;
  demodPkg::legacyIn_t                          legacy;
  demodPkg::regAddr_e                           addr;
  logic [demodPkg::NUM_DAC-1:0][MSB:0]          dacData;
  logic                                         dacRst;
  demodPkg::decBits_t                           dec;
  logic [demodPkg::PHERR_WIDTH-1:0]             phaseError;
  logic                                         phaseErrorEn;
  logic [demodPkg::BUS_WIDTH-1:0]               rdData;

  // Cycle model state, each value as it stands after the next edge
  stimRec_t                                     s1 = '0;
  demodPkg::dacWord_t [demodPkg::NUM_DAC-1:0]   s2Dac = '0;
  demodPkg::decBits_t                           decM = '0;
  demodPkg::legacyIn_t                          legDly = '0;
  logic [demodPkg::NUM_DAC-1:0][MSB:0]          holdM = '0;
  logic [demodPkg::BUS_WIDTH-1:0]               rdM = '0;

  demodOutTop #(.VER_NUMBER(VERSION), .RESET_HOLD(HOLD_CYCLES)) DUT (
    .ck933 (ck933), .rs_i (rs), .mode_i (mode), .dacSel_i (dacSel), .extDac_i (extDac),
    .trellis_i (trellis), .legacy_i (legacy), .cs_i (cs), .rd_i (rd), .addr_i (addr),
    .dacData_o (dacData), .dacRst_o (dacRst), .dec_o (dec), .phaseError_o (phaseError),
    .phaseErrorEn_o (phaseErrorEn), .rdData_o (rdData)
  );

  initial begin
    ck933 = 1'b0;
    forever #2 ck933 = ~ck933;
  end

  // ********************************************************************
  // Reference rules
  // ********************************************************************
  function automatic demodPkg::dacWord_t refDacWord(input demodPkg::demodMode_e md,
      input demodPkg::dacSel_e sel, input demodPkg::dacWord_t ext,
      input demodPkg::trellisCh_t tch);
    demodPkg::dacWord_t w;
    logic trellisSrc;
    trellisSrc = (sel == demodPkg::DAC_TRELLIS_I) || (sel == demodPkg::DAC_TRELLIS_Q) ||
                 (sel == demodPkg::DAC_TRELLIS_PHERR) || (sel == demodPkg::DAC_TRELLIS_INDEX);
    if (md == demodPkg::MODE_MULTIH && trellisSrc) begin
      w.data = tch.data[demodPkg::TRELLIS_WIDTH-1 -: demodPkg::DAC_WIDTH];  // Top bits only
      w.sync = tch.sync;
    end else begin
      w.data = ext.data;
      w.sync = 1'b1;
    end
    return w;
  endfunction

  // Legacy bits arrive one cycle behind the mode that routes them
  function automatic demodPkg::decBits_t refDec(input stimRec_t rec,
      input demodPkg::legacyIn_t prevLeg);
    if (rec.mode == demodPkg::MODE_MULTIH) begin
      return '{rec.trellis.decision[0], rec.trellis.decision[1], rec.trellis.symEn,
               rec.trellis.sym2xEn};
    end
    return '{prevLeg.iData, prevLeg.qData, prevLeg.symEn, prevLeg.sym2xEn};
  endfunction

  function automatic logic [MSB:0] toOffset(input logic [MSB:0] w);
    return w ^ {1'b1, {MSB{1'b0}}};
  endfunction

  // ********************************************************************
  // Compare tasks
  // ********************************************************************
  task automatic stopWithFailure(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic checkDac(input int ch, input logic [MSB:0] exp, input logic [MSB:0] act);
    if (act !== exp)
      stopWithFailure($sformatf("[ERROR] dacData_o[%0d] expected %h got %h at %0t",
                                ch, exp, act, $time));
  endtask

  task automatic checkDec(input demodPkg::decBits_t exp, input demodPkg::decBits_t act);
    if (act !== exp)
      stopWithFailure($sformatf("[ERROR] dec_o expected %h got %h at %0t", exp, act, $time));
  endtask

  task automatic checkRead(input logic [demodPkg::BUS_WIDTH-1:0] exp,
                           input logic [demodPkg::BUS_WIDTH-1:0] act);
    if (act !== exp)
      stopWithFailure($sformatf("[ERROR] rdData_o expected %h got %h at %0t", exp, act, $time));
  endtask

  task automatic checkPhase(input logic [demodPkg::PHERR_WIDTH-1:0] exp, input logic expEn,
                            input logic [demodPkg::PHERR_WIDTH-1:0] act, input logic actEn);
    if ({actEn, act} !== {expEn, exp})
      stopWithFailure($sformatf("[ERROR] phaseErrorEn_o,phaseError_o expected %h got %h at %0t",
                                {expEn, exp}, {actEn, act}, $time));
  endtask

  // Compare, then step the model across the coming edge
  always @(negedge ck933) begin
    if (dacRst) begin
      for (int ch = 0; ch < demodPkg::NUM_DAC; ch++) checkDac(ch, '0, dacData[ch]);
      checkDec('0, dec);
      checkPhase('0, 1'b0, phaseError, phaseErrorEn);
      s1 = '0;
      s2Dac = '0;
      decM = '0;
      legDly = '0;
      holdM = '0;
    end else begin
      for (int ch = 0; ch < demodPkg::NUM_DAC; ch++) checkDac(ch, holdM[ch], dacData[ch]);
      checkDec(decM, dec);
      checkPhase(s1.trellis.phaseError, s1.trellis.phaseErrorEn, phaseError, phaseErrorEn);
      for (int ch = 0; ch < demodPkg::NUM_DAC; ch++) begin
        if (s2Dac[ch].sync) holdM[ch] = toOffset(s2Dac[ch].data);
        s2Dac[ch] = refDacWord(s1.mode, s1.sel[ch], s1.ext[ch], s1.trellis.ch[ch]);
      end
      decM = refDec(s1, legDly);
      legDly = s1.legacy;
      s1 = '{mode, dacSel, extDac, trellis, legacy};
    end
    checkRead(rdM, rdData);
    rdM = (!rs && cs && rd && addr == demodPkg::REG_VERSION) ? VERSION : '0;
  end

  // ********************************************************************
  // Stimulus
  // ********************************************************************
  task automatic driveRandomCycle();
    logic [31:0] r;
    logic [95:0] wide;
    @(posedge ck933);
    r = $random(seed);
    wide = {$random(seed), $random(seed), $random(seed)};
    mode <= (r[2:0] == 3'd0) ? demodPkg::MODE_AUQPSK :
            (r[3] ? demodPkg::MODE_MULTIH : demodPkg::MODE_LEGACY);
    for (int ch = 0; ch < demodPkg::NUM_DAC; ch++) begin
      dacSel[ch] <= demodPkg::dacSel_e'({1'b0, wide[3*ch +: 3]});  // Codes 5..7 are external
      extDac[ch] <= wide[80 - 15*ch -: 15];
    end
    trellis <= wide[$bits(demodPkg::trellisOut_t)-1:0] ^ {r, r, r[5:0]};
    legacy <= r[7:4];
    cs <= r[8];
    rd <= r[9];
    addr <= r[10] ? demodPkg::REG_VERSION : demodPkg::regAddr_e'({r[21:11], 1'b1});
  endtask

  task automatic readRegister(input demodPkg::regAddr_e a,
                              input logic [demodPkg::BUS_WIDTH-1:0] exp);
    @(posedge ck933);
    cs <= 1'b1;
    rd <= 1'b1;
    addr <= a;
    @(posedge ck933);
    cs <= 1'b0;
    rd <= 1'b0;
    @(negedge ck933);
    checkRead(exp, rdData);
  endtask

  task automatic waitCoreRelease();
    int waited;
    waited = 0;
    while (dacRst && waited < 50) begin
      @(negedge ck933);
      waited++;
    end
    if (dacRst) stopWithFailure("Timeout: dacRst_o never released after reset");
  endtask

  // Window starts 2 edges after the edge that drives the read
  task automatic softResetWindow();
    int waited;
    int highCnt;
    @(posedge ck933);
    cs <= 1'b1;
    rd <= 1'b1;
    addr <= demodPkg::REG_RESET;
    @(posedge ck933);
    cs <= 1'b0;
    rd <= 1'b0;
    waited = 0;
    do begin
      @(negedge ck933);
      waited++;
    end while (!dacRst && waited < 10);
    if (!dacRst) stopWithFailure("Timeout: dacRst_o never rose after the soft reset read");
    if (waited != 2)
      stopWithFailure($sformatf("[ERROR] dacRst_o start delay expected %h got %h", 2, waited));
    highCnt = 0;
    do begin
      highCnt++;
      @(negedge ck933);
    end while (dacRst && highCnt < HOLD_CYCLES + 10);
    if (dacRst) stopWithFailure("Timeout: dacRst_o stuck high after the soft reset");
    if (highCnt != HOLD_CYCLES)
      stopWithFailure($sformatf("[ERROR] dacRst_o high cycles expected %h got %h",
                                HOLD_CYCLES, highCnt));
  endtask

  initial begin
    rs = 1'b1;
    cs = 1'b0;
    rd = 1'b0;
    addr = demodPkg::REG_VERSION;
    mode = demodPkg::MODE_LEGACY;
    dacSel = '0;
    extDac = '0;
    trellis = '0;
    legacy = '0;
    repeat (8) @(posedge ck933);
    rs <= 1'b0;
    waitCoreRelease();
    readRegister(demodPkg::REG_VERSION, VERSION);
    readRegister(demodPkg::regAddr_e'(12'h005), '0);
    repeat (600) driveRandomCycle();
    softResetWindow();
    readRegister(demodPkg::REG_VERSION, VERSION);
    repeat (300) driveRandomCycle();
    repeat (4) @(posedge ck933);
    if (DUT.uProps.failCount == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      stopWithFailure("Bound assertions reported failures");
    end
  end

endmodule

// ==== tb/demodOut_properties.sv ====
// Bound checks on soft reset stretching, symbol enable under reset and read data idling
`timescale 1ns/1ps

module demodOutProperties #(
  parameter int RESET_HOLD = 5
) (
  input logic                           ck933,
  input logic                           rs_i,
  input logic                           softReset_i,
  input logic                           coreReset_i,
  input logic                           symEn_i,
  input logic                           cs_i,
  input logic                           rd_i,
  input logic [demodPkg::BUS_WIDTH-1:0] rdData_i
);

  int unsigned failCount = 0;   // Failed assertion count

  // ********************************************************************
  // Soft reset window, high on cycles 1..RESET_HOLD after the strobe
  // ********************************************************************
  for (genvar n = 1; n <= RESET_HOLD; n++) begin : gHold
    holdHigh: assert property (@(posedge ck933) disable iff (rs_i)
      $past(softReset_i, n) |-> coreReset_i)
      else begin
        $error("coreReset low %0d cycles after a soft reset strobe", n);
        failCount++;
      end
  end

  holdRelease: assert property (@(posedge ck933) disable iff (rs_i)
    $past(softReset_i, RESET_HOLD + 1) |-> !coreReset_i)
    else begin
      $error("coreReset still high after the soft reset window");
      failCount++;
    end

  // Both flushed stages keep symEn low for two cycles past coreReset
  symEnQuiet: assert property (@(posedge ck933)
    (coreReset_i || $past(coreReset_i) || $past(coreReset_i, 2)) |-> !symEn_i)
    else begin
      $error("symEn high under coreReset or in the two cycles after it");
      failCount++;
    end

  // Bus returns to zero after any cycle without a read
  rdIdle: assert property (@(posedge ck933) disable iff (rs_i)
    !(cs_i && rd_i) |=> (rdData_i == '0))
    else begin
      $error("rdData nonzero without a preceding read");
      failCount++;
    end

endmodule

bind demodOutTop demodOutProperties #(.RESET_HOLD(RESET_HOLD)) uProps (
  .ck933       (ck933),
  .rs_i        (rs_i),
  .softReset_i (softReset),
  .coreReset_i (coreReset),
  .symEn_i     (dec_o.symEn),
  .cs_i        (cs_i),
  .rd_i        (rd_i),
  .rdData_i    (rdData_o)
);

// ==== rtl/demodOutTop.sv ====
// Multi-h demodulator output side, reclock, source select and DAC drive with register block
`timescale 1ns/1ps

module demodOutTop #(
  parameter logic [demodPkg::BUS_WIDTH-1:0] VER_NUMBER = 16'h0079,
  parameter int                             RESET_HOLD = 5
) (
  input  logic                                                   ck933,
  input  logic                                                   rs_i,
  input  demodPkg::demodMode_e                                   mode_i,
  input  demodPkg::dacSel_e [demodPkg::NUM_DAC-1:0]              dacSel_i,
  input  demodPkg::dacWord_t [demodPkg::NUM_DAC-1:0]             extDac_i,
  input  demodPkg::trellisOut_t                                  trellis_i,
  input  demodPkg::legacyIn_t                                    legacy_i,
  input  logic                                                   cs_i,
  input  logic                                                   rd_i,
  input  demodPkg::regAddr_e                                     addr_i,
  output logic [demodPkg::NUM_DAC-1:0][demodPkg::DAC_WIDTH-1:0]  dacData_o,
  output logic                                                   dacRst_o,
  output demodPkg::decBits_t                                     dec_o,
  output logic [demodPkg::PHERR_WIDTH-1:0]                       phaseError_o,
  output logic                                                   phaseErrorEn_o,
  output logic [demodPkg::BUS_WIDTH-1:0]                         rdData_o
);

  logic                                          coreReset;
  logic                                          softReset;
  demodPkg::demodMode_e                          modeQ;
  demodPkg::dacSel_e [demodPkg::NUM_DAC-1:0]     dacSelQ;
  demodPkg::dacWord_t [demodPkg::NUM_DAC-1:0]    extDacQ;
  demodPkg::trellisOut_t                         trellisQ;
  demodPkg::legacyIn_t                           legacyQ;
  demodPkg::dacWord_t [demodPkg::NUM_DAC-1:0]    dacWord;

  // ********************************************************************
  // Register block and core reset
  // ********************************************************************
  miscRegs #(.VER_NUMBER(VER_NUMBER)) uMiscRegs (
    .ck933       (ck933),
    .rs_i        (rs_i),
    .cs_i        (cs_i),
    .rd_i        (rd_i),
    .addr_i      (addr_i),
    .rdData_o    (rdData_o),
    .softReset_o (softReset)
  );

  resetStretch #(.RESET_HOLD(RESET_HOLD)) uResetStretch (
    .ck933       (ck933),
    .rs_i        (rs_i),
    .softReset_i (softReset),
    .coreReset_o (coreReset)
  );

  assign dacRst_o = coreReset;   // Converters share the core reset

  // ********************************************************************
  // Output pipeline
  // ********************************************************************
  inputReclock uInputReclock (
    .ck933          (ck933),
    .rs_i           (coreReset),
    .mode_i         (mode_i),
    .dacSel_i       (dacSel_i),
    .extDac_i       (extDac_i),
    .trellis_i      (trellis_i),
    .legacy_i       (legacy_i),
    .modeQ_o        (modeQ),
    .dacSelQ_o      (dacSelQ),
    .extDacQ_o      (extDacQ),
    .trellisQ_o     (trellisQ),
    .legacyQ_o      (legacyQ),
    .phaseError_o   (phaseError_o),
    .phaseErrorEn_o (phaseErrorEn_o)
  );

  sourceSelect uSourceSelect (
    .ck933      (ck933),
    .rs_i       (coreReset),
    .modeQ_i    (modeQ),
    .dacSelQ_i  (dacSelQ),
    .extDacQ_i  (extDacQ),
    .trellisQ_i (trellisQ),
    .legacyQ_i  (legacyQ),
    .dacWord_o  (dacWord),
    .dec_o      (dec_o)
  );

  dacDrive uDacDrive (
    .ck933     (ck933),
    .rs_i      (coreReset),
    .dacWord_i (dacWord),
    .dacData_o (dacData_o)
  );

endmodule

// ==== rtl/resetStretch.sv ====
// Core reset generator, stretches external and soft resets to a fixed hold count
`timescale 1ns/1ps

module resetStretch #(
  parameter int RESET_HOLD = 5
) (
  input  logic ck933,
  input  logic rs_i,
  input  logic softReset_i,
  output logic coreReset_o
);

  localparam int CNT_WIDTH = $clog2(RESET_HOLD + 1);

  logic                 armQ;      // Set by rs_i, fires the counter on release
  logic [CNT_WIDTH-1:0] holdCnt;

  always_ff @(posedge ck933 or posedge rs_i) begin
    if (rs_i) begin
      armQ    <= 1'b1;
      holdCnt <= '0;
    end else if (armQ || softReset_i) begin
      armQ    <= 1'b0;
      holdCnt <= CNT_WIDTH'(RESET_HOLD);
    end else if (holdCnt != '0) begin
      holdCnt <= holdCnt - 1'b1;
    end
  end

  // ********************************************************************
  // High during rs_i, until the arm flag fires, and while counting
  // ********************************************************************
  assign coreReset_o = rs_i | armQ | (holdCnt != '0);

endmodule

// ==== rtl/miscRegs.sv ====
// Miscellaneous register space with the version read and the soft reset strobe
`timescale 1ns/1ps

module miscRegs #(
  parameter logic [demodPkg::BUS_WIDTH-1:0] VER_NUMBER = 16'h0079
) (
  input  logic                              ck933,
  input  logic                              rs_i,        // External reset only
  input  logic                              cs_i,
  input  logic                              rd_i,
  input  demodPkg::regAddr_e                addr_i,
  output logic [demodPkg::BUS_WIDTH-1:0]    rdData_o,
  output logic                              softReset_o
);

  logic rdStrobe;

  assign rdStrobe = cs_i & rd_i;

  // ********************************************************************
  // Address decode and read data
  // ********************************************************************
  always_ff @(posedge ck933 or posedge rs_i) begin
    if (rs_i) begin
      rdData_o    <= '0;
      softReset_o <= 1'b0;
    end else begin
      rdData_o    <= '0;          // Bus idles at zero
      softReset_o <= 1'b0;
      if (rdStrobe) begin
        case (addr_i)
          demodPkg::REG_VERSION: begin
            rdData_o <= VER_NUMBER;
          end
          demodPkg::REG_RESET: begin
            softReset_o <= 1'b1;    // Read returns no data
          end
          default: begin
            rdData_o <= '0;
          end
        endcase
      end
    end
  end

  // Kept off coreReset so the version stays readable
  // while the soft reset window is open

endmodule

// ==== rtl/dacDrive.sv ====
// Stage 3 of the output pipeline, sync-loaded DAC hold registers in offset binary
`timescale 1ns/1ps

module dacDrive (
  input  logic                                                   ck933,
  input  logic                                                   rs_i,
  input  demodPkg::dacWord_t [demodPkg::NUM_DAC-1:0]             dacWord_i,
  output logic [demodPkg::NUM_DAC-1:0][demodPkg::DAC_WIDTH-1:0]  dacData_o
);

  localparam int MSB = demodPkg::DAC_WIDTH - 1;

  // ********************************************************************
  // Hold registers, one per channel
  // ********************************************************************
  always_ff @(posedge ck933 or posedge rs_i) begin
    if (rs_i) begin
      dacData_o <= '0;
    end else begin
      for (int i = 0; i < demodPkg::NUM_DAC; i++) begin
        // Output holds between syncs
        if (dacWord_i[i].sync) begin
          dacData_o[i] <= {~dacWord_i[i].data[MSB], dacWord_i[i].data[MSB-1:0]};
        end
      end
    end
  end

  // Two's complement in, offset binary out for the converter

endmodule

// ==== rtl/sourceSelect.sv ====
// Stage 2 of the output pipeline, picks DAC channel sources and the decision bit source by mode
`timescale 1ns/1ps

module sourceSelect (
  input  logic                                           ck933,
  input  logic                                           rs_i,
  input  demodPkg::demodMode_e                           modeQ_i,
  input  demodPkg::dacSel_e [demodPkg::NUM_DAC-1:0]      dacSelQ_i,
  input  demodPkg::dacWord_t [demodPkg::NUM_DAC-1:0]     extDacQ_i,
  input  demodPkg::trellisOut_t                          trellisQ_i,
  input  demodPkg::legacyIn_t                            legacyQ_i,
  output demodPkg::dacWord_t [demodPkg::NUM_DAC-1:0]     dacWord_o,
  output demodPkg::decBits_t                             dec_o
);

  localparam int TOP = demodPkg::TRELLIS_WIDTH - 1;

  logic                multihMode;
  demodPkg::legacyIn_t legacyDly;   // Extra stage on the legacy stream

  assign multihMode = (modeQ_i == demodPkg::MODE_MULTIH);

  function automatic logic isTrellisSel(input demodPkg::dacSel_e sel);
    case (sel)
      demodPkg::DAC_TRELLIS_I,
      demodPkg::DAC_TRELLIS_Q,
      demodPkg::DAC_TRELLIS_PHERR,
      demodPkg::DAC_TRELLIS_INDEX: isTrellisSel = 1'b1;
      default:                     isTrellisSel = 1'b0;
    endcase
  endfunction

  always_ff @(posedge ck933 or posedge rs_i) begin
    if (rs_i) begin
      legacyDly <= '0;
      dacWord_o <= '0;
      dec_o     <= '0;
    end else begin
      legacyDly <= legacyQ_i;

      // ******************************************************************
      // DAC channel sources
      // ******************************************************************
      for (int i = 0; i < demodPkg::NUM_DAC; i++) begin
        if (multihMode && isTrellisSel(dacSelQ_i[i])) begin
          dacWord_o[i].data <= trellisQ_i.ch[i].data[TOP -: demodPkg::DAC_WIDTH];
          dacWord_o[i].sync <= trellisQ_i.ch[i].sync;
        end else begin
          dacWord_o[i].data <= extDacQ_i[i].data;
          dacWord_o[i].sync <= 1'b1;   // External words load every cycle
        end
      end

      // ******************************************************************
      // Decision bits
      // ******************************************************************
      if (multihMode) begin
        dec_o.iBit    <= trellisQ_i.decision[0];
        dec_o.qBit    <= trellisQ_i.decision[1];
        dec_o.symEn   <= trellisQ_i.symEn;
        dec_o.sym2xEn <= trellisQ_i.sym2xEn;
      end else begin
        dec_o.iBit    <= legacyDly.iData;
        dec_o.qBit    <= legacyDly.qData;
        dec_o.symEn   <= legacyDly.symEn;
        dec_o.sym2xEn <= legacyDly.sym2xEn;
      end
    end
  end

endmodule

// ==== rtl/inputReclock.sv ====
// Stage 1 of the output pipeline, registers every external input into the ck933 domain
`timescale 1ns/1ps

module inputReclock (
  input  logic                                           ck933,
  input  logic                                           rs_i,
  input  demodPkg::demodMode_e                           mode_i,
  input  demodPkg::dacSel_e [demodPkg::NUM_DAC-1:0]      dacSel_i,
  input  demodPkg::dacWord_t [demodPkg::NUM_DAC-1:0]     extDac_i,
  input  demodPkg::trellisOut_t                          trellis_i,
  input  demodPkg::legacyIn_t                            legacy_i,
  output demodPkg::demodMode_e                           modeQ_o,
  output demodPkg::dacSel_e [demodPkg::NUM_DAC-1:0]      dacSelQ_o,
  output demodPkg::dacWord_t [demodPkg::NUM_DAC-1:0]     extDacQ_o,
  output demodPkg::trellisOut_t                          trellisQ_o,
  output demodPkg::legacyIn_t                            legacyQ_o,
  output logic [demodPkg::PHERR_WIDTH-1:0]               phaseError_o,
  output logic                                           phaseErrorEn_o
);

  always_ff @(posedge ck933 or posedge rs_i) begin
    if (rs_i) begin
      modeQ_o    <= demodPkg::MODE_LEGACY;
      extDacQ_o  <= '0;
      trellisQ_o <= '0;
      legacyQ_o  <= '0;
      for (int i = 0; i < demodPkg::NUM_DAC; i++) begin
        dacSelQ_o[i] <= demodPkg::DAC_EXTERNAL;
      end
    end else begin
      modeQ_o    <= mode_i;
      dacSelQ_o  <= dacSel_i;
      extDacQ_o  <= extDac_i;
      trellisQ_o <= trellis_i;     // Decoder runs off its own timing
      legacyQ_o  <= legacy_i;
    end
  end

  // Phase error feedback leaves straight from the reclocked copy
  assign phaseError_o   = trellisQ_o.phaseError;
  assign phaseErrorEn_o = trellisQ_o.phaseErrorEn;

endmodule

// ==== rtl/demodPkg.sv ====
// Shared widths, mode and select codes, and bundled buses for the demodulator output side
package demodPkg;

  localparam int DAC_WIDTH     = 14;
  localparam int TRELLIS_WIDTH = 18;  // Top DAC_WIDTH bits go to a DAC
  localparam int PHERR_WIDTH   = 8;
  localparam int BUS_WIDTH     = 16;
  localparam int ADDR_WIDTH    = 12;
  localparam int NUM_DAC       = 3;

  typedef enum logic [3:0] {
    MODE_LEGACY = 4'h0,
    MODE_AUQPSK = 4'h1,
    MODE_MULTIH = 4'h2
  } demodMode_e;

  // Only the four trellis codes pick monitor data
  typedef enum logic [3:0] {
    DAC_EXTERNAL      = 4'h0,
    DAC_TRELLIS_I     = 4'h1,
    DAC_TRELLIS_Q     = 4'h2,
    DAC_TRELLIS_PHERR = 4'h3,
    DAC_TRELLIS_INDEX = 4'h4
  } dacSel_e;

  typedef enum logic [ADDR_WIDTH-1:0] {
    REG_RESET   = 12'h000,
    REG_VERSION = 12'h002
  } regAddr_e;

  typedef struct packed {
    logic [DAC_WIDTH-1:0] data;
    logic                 sync;
  } dacWord_t;

  typedef struct packed {
    logic [TRELLIS_WIDTH-1:0] data;
    logic                     sync;
  } trellisCh_t;

  typedef struct packed {
    trellisCh_t [NUM_DAC-1:0] ch;            // Monitor sample per DAC channel
    logic [1:0]               decision;      // Bit 0 is I, bit 1 is Q
    logic                     symEn;
    logic                     sym2xEn;
    logic [PHERR_WIDTH-1:0]   phaseError;
    logic                     phaseErrorEn;
  } trellisOut_t;

  typedef struct packed {
    logic iData;
    logic qData;
    logic symEn;
    logic sym2xEn;
  } legacyIn_t;

  // Bit stream toward the decoder
  typedef struct packed {
    logic iBit;
    logic qBit;
    logic symEn;
    logic sym2xEn;
  } decBits_t;

endpackage
